// ==== bench/write_buffer_checker.sv ====
`timescale 1ns/1ps

module write_buffer_checker (
  input logic                       clock,
  input logic                       rstn,
  input logic                       enabled,
  input logic                       read_valid,
  input afu_buffer_pkg::half_line_t read_data,
  input afu_buffer_pkg::dw_parity_t read_parity,
  input logic                       tag_parity_error
);

  // failed assertions, read back by the bench at the end
  int assertion_failures = 0;

  // odd parity per doubleword, from a ones count
  function automatic afu_buffer_pkg::dw_parity_t odd_bits(
    input afu_buffer_pkg::half_line_t d
  );
    afu_buffer_pkg::dw_parity_t p;
    for (int i = 0; i < 8; i++) begin
      p[i] = ($countones(d[i*64 +: 64]) % 2) == 0;
    end
    return p;
  endfunction

  // two pulses in a row need two accepted requests in a row
  pulse_a: assert property (@(posedge clock) disable iff (!rstn)
    tag_parity_error && $past(tag_parity_error) |->
      $past(read_valid && enabled, 2) && $past(read_valid && enabled, 3))
    else begin
      $error("tag parity error stayed high without back-to-back requests");
      assertion_failures++;
    end

  // parity tracks the data, idle value too
  parity_a: assert property (@(posedge clock) disable iff (!rstn)
    read_parity == odd_bits(read_data))
    else begin
      $error("read parity does not match read data");
      assertion_failures++;
    end

  // no accepted request, all ones next cycle
  idle_a: assert property (@(posedge clock) disable iff (!rstn)
    !(read_valid && enabled) |=> read_data == '1)
    else begin
      $error("idle read port did not drive all ones");
      assertion_failures++;
    end

endmodule

// ==== bench/write_buffer_monitor.sv ====
`timescale 1ns/1ps

module write_buffer_monitor (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       enabled,
  input  logic                       write_valid,
  input  afu_buffer_pkg::tag_t       write_tag,
  input  afu_buffer_pkg::half_line_t write_data_0,
  input  afu_buffer_pkg::half_line_t write_data_1,
  input  logic                       read_valid,
  input  afu_buffer_pkg::tag_t       read_tag,
  input  logic                       read_tag_parity,
  input  afu_buffer_pkg::read_addr_t read_address,
  input  afu_buffer_pkg::half_line_t read_data,
  input  afu_buffer_pkg::dw_parity_t read_parity,
  input  logic                       tag_parity_error,
  output int                         data_errors,
  output int                         parity_errors,
  output int                         flag_errors
);

  // shadow of both memories, one entry per tag
  afu_buffer_pkg::half_line_t mirror_0 [256];
  afu_buffer_pkg::half_line_t mirror_1 [256];

  // expected outputs, error runs one stage later
  afu_buffer_pkg::half_line_t exp_data;
  afu_buffer_pkg::dw_parity_t exp_parity;
  logic                       exp_err_next;
  logic                       exp_err;

  // parity bit that makes the ones count odd
  function automatic logic odd_bit(input logic [63:0] v);
    return ($countones(v) % 2) == 0;
  endfunction

  // expected response as {error, parity, data}
  function automatic logic [520:0] reference_response(
    input logic                       accepted,
    input afu_buffer_pkg::tag_t       tag,
    input logic                       tag_par,
    input afu_buffer_pkg::read_addr_t addr
  );
    afu_buffer_pkg::half_line_t data;
    afu_buffer_pkg::dw_parity_t par;
    logic                       err;
    data = '1;
    err  = 1'b0;
    if (accepted) begin
      data = (addr == '0) ? mirror_0[tag] : mirror_1[tag];
      err  = tag_par != odd_bit({56'd0, tag});
    end
    for (int i = 0; i < 8; i++) begin
      par[i] = odd_bit(data[i*64 +: 64]);
    end
    return {err, par, data};
  endfunction

  initial begin
    data_errors   = 0;
    parity_errors = 0;
    flag_errors   = 0;
  end

  ////////////////////
  // model
  ////////////////////

  // read sees the mirror before this edge's write lands
  always @(posedge clock) begin
    exp_err <= rstn ? exp_err_next : 1'b0;
    {exp_err_next, exp_parity, exp_data} <= reference_response(
      rstn && read_valid && enabled, read_tag, read_tag_parity, read_address);
    if (rstn && write_valid) begin
      mirror_0[write_tag] = write_data_0;
      mirror_1[write_tag] = write_data_1;
    end
  end

  ////////////////////
  // compare
  ////////////////////

  // mid-cycle, outputs are settled
  always @(negedge clock) begin
    if (read_data !== exp_data) begin
      data_errors++;
      $display("error at %0t: read_data expected %h got %h", $time, exp_data, read_data);
    end
    if (read_parity !== exp_parity) begin
      parity_errors++;
      $display("error at %0t: read_parity expected %h got %h", $time, exp_parity,
               read_parity);
    end
    if (tag_parity_error !== exp_err) begin
      flag_errors++;
      $display("error at %0t: tag_parity_error expected %b got %b", $time, exp_err,
               tag_parity_error);
    end
  end

endmodule

// ==== bench/write_buffer_tb.sv ====
`timescale 1ns/1ps

module write_buffer_tb;

  // about twice the stimulus length
  localparam int CYCLE_LIMIT = 4000;

  logic                       clock = 1'b0;
  logic                       rstn;
  logic                       enabled;
  logic                       write_valid;
  afu_buffer_pkg::tag_t       write_tag;
  afu_buffer_pkg::half_line_t write_data_0;
  afu_buffer_pkg::half_line_t write_data_1;
  logic                       read_valid;
  afu_buffer_pkg::tag_t       read_tag;
  logic                       read_tag_parity;
  afu_buffer_pkg::read_addr_t read_address;
  afu_buffer_pkg::half_line_t read_data;
  afu_buffer_pkg::dw_parity_t read_parity;
  logic                       tag_parity_error;

  // counts from the monitor
  int data_errors;
  int parity_errors;
  int flag_errors;
  int timeout_errors = 0;
  int cycles = 0;

  write_buffer_top dut_i (.*);
  write_buffer_monitor mon_i (.*);

  bind write_buffer_top write_buffer_checker checker_i (.*);

  always #4 clock = ~clock;

  // eight doublewords of random bits
  function automatic afu_buffer_pkg::half_line_t random_half_line();
    afu_buffer_pkg::half_line_t v;
    for (int i = 0; i < 16; i++) begin
      v[i*32 +: 32] = $urandom;
    end
    return v;
  endfunction

  // one cycle of stimulus on the falling edge
  // bad_par flips the host tag parity bit
  task automatic drive_cycle(
    input logic                       wv,
    input afu_buffer_pkg::tag_t       wt,
    input logic                       rv,
    input afu_buffer_pkg::tag_t       rt,
    input logic                       bad_par,
    input afu_buffer_pkg::read_addr_t ra
  );
    @(negedge clock);
    write_valid     = wv;
    write_tag       = wt;
    write_data_0    = random_half_line();
    write_data_1    = random_half_line();
    read_valid      = rv;
    read_tag        = rt;
    read_tag_parity = ~(^rt) ^ bad_par;
    read_address    = ra;
  endtask

  // closing line and verdict
  task automatic finish_run();
    int checker_errors;
    checker_errors = dut_i.checker_i.assertion_failures;
    $display("errors: data %0d, parity %0d, flag %0d, assertions %0d, timeout %0d",
             data_errors, parity_errors, flag_errors, checker_errors, timeout_errors);
    if (data_errors + parity_errors + flag_errors + checker_errors + timeout_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  ////////////////////
  // timeout
  ////////////////////

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: stimulus still running after %0d cycles", cycles);
      timeout_errors++;
      finish_run();
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    afu_buffer_pkg::tag_t       wt;
    afu_buffer_pkg::tag_t       rt;
    afu_buffer_pkg::tag_t       prev_wt;
    afu_buffer_pkg::read_addr_t addr;
    logic                       wv;
    logic                       rv;
    logic                       bad;
    logic                       prev_wv;
    void'($urandom(32'h76ed));
    rstn            = 1'b0;
    enabled         = 1'b1;
    write_valid     = 1'b0;
    write_tag       = '0;
    write_data_0    = '0;
    write_data_1    = '0;
    read_valid      = 1'b0;
    read_tag        = '0;
    read_tag_parity = 1'b1;
    read_address    = '0;
    repeat (3) @(negedge clock);
    rstn = 1'b1;
    // fill every tag
    for (int t = 0; t < 256; t++) begin
      drive_cycle(1'b1, afu_buffer_pkg::tag_t'(t), 1'b0, '0, 1'b0, '0);
    end
    // both halves of every tag back to back
    for (int t = 0; t < 256; t++) begin
      rt   = afu_buffer_pkg::tag_t'(t);
      addr = afu_buffer_pkg::read_addr_t'(1 + $urandom_range(62));
      drive_cycle(1'b0, '0, 1'b1, rt, 1'b0, '0);
      drive_cycle(1'b0, '0, 1'b1, rt, 1'b0, addr);
    end
    // idle value and its parity
    repeat (4) drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
    // random tag parity about half wrong
    // gaps now and then
    for (int i = 0; i < 300; i++) begin
      rt   = afu_buffer_pkg::tag_t'($urandom_range(255));
      bad  = $urandom_range(1) != 0;
      addr = afu_buffer_pkg::read_addr_t'($urandom_range(63));
      drive_cycle(1'b0, '0, 1'b1, rt, bad, addr);
      if ($urandom_range(3) == 0) begin
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
      end
    end
    // port disabled so requests are dropped
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
    enabled = 1'b0;
    for (int i = 0; i < 100; i++) begin
      rt   = afu_buffer_pkg::tag_t'($urandom_range(255));
      bad  = $urandom_range(1) != 0;
      addr = afu_buffer_pkg::read_addr_t'($urandom_range(63));
      drive_cycle(1'b0, '0, 1'b1, rt, bad, addr);
    end
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
    enabled = 1'b1;
    // mixed traffic
    // reads keep clear of tags written this cycle or the one before
    prev_wv = 1'b0;
    prev_wt = '0;
    for (int i = 0; i < 600; i++) begin
      wv   = $urandom_range(1) != 0;
      rv   = $urandom_range(3) != 0;
      wt   = afu_buffer_pkg::tag_t'($urandom_range(255));
      rt   = afu_buffer_pkg::tag_t'($urandom_range(255));
      addr = afu_buffer_pkg::read_addr_t'($urandom_range(63));
      while ((wv && rt == wt) || (prev_wv && rt == prev_wt)) begin
        rt = afu_buffer_pkg::tag_t'($urandom_range(255));
      end
      drive_cycle(wv, wt, rv, rt, 1'b0, addr);
      prev_wv = wv;
      prev_wt = wt;
    end
    // drain the pipeline
    repeat (4) drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
    finish_run();
  end

endmodule

// ==== build.f ====
rtl/afu_buffer_pkg.sv
rtl/write_stage.sv
rtl/half_line_ram.sv
rtl/buffer_read_port.sv
rtl/write_buffer_top.sv
bench/write_buffer_checker.sv
bench/write_buffer_monitor.sv
bench/write_buffer_tb.sv

// ==== rtl/afu_buffer_pkg.sv ====
package afu_buffer_pkg;

  ////////////////////
  // widths
  ////////////////////

  // doubleword size and count per half-line
  localparam int DW_BITS  = 64;
  localparam int DW_COUNT = 8;

  // command or buffer tag
  // 256 entries in each half-line memory
  typedef logic [7:0] tag_t;

  // half a cache line
  // eight doublewords, dw i at bits 64*i +: 64
  typedef logic [DW_BITS*DW_COUNT-1:0] half_line_t;

  // host buffer read address
  // zero picks half 0, anything else half 1
  typedef logic [5:0] read_addr_t;

  // one parity bit per doubleword
  typedef logic [DW_COUNT-1:0] dw_parity_t;

  ////////////////////
  // parity
  ////////////////////

  // odd parity per doubleword
  // ones in the dw plus its parity bit give an odd count
  function automatic dw_parity_t dw_odd_parity(input half_line_t data);
    dw_parity_t par;
    par = '0;
    for (int i = 0; i < DW_COUNT; i++) begin
      // xnor reduce gives the odd-parity bit
      par[i] = ~(^data[i*DW_BITS +: DW_BITS]);
    end
    return par;
  endfunction

endpackage

// ==== rtl/buffer_read_port.sv ====
`timescale 1ns/1ps

module buffer_read_port (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       enabled,
  // host buffer read request
  input  logic                       read_valid,
  input  afu_buffer_pkg::tag_t       read_tag,
  input  logic                       read_tag_parity,
  input  afu_buffer_pkg::read_addr_t read_address,
  // registered memory outputs
  input  afu_buffer_pkg::half_line_t ram_data_0,
  input  afu_buffer_pkg::half_line_t ram_data_1,
  // host buffer read response
  output afu_buffer_pkg::half_line_t read_data,
  output afu_buffer_pkg::dw_parity_t read_parity,
  output logic                       tag_parity_error
);

  // request taken this cycle
  logic req_accept;

  // request registers
  logic                       req_valid_q;
  afu_buffer_pkg::tag_t       req_tag_q;
  logic                       req_tag_parity_q;
  afu_buffer_pkg::read_addr_t req_address_q;

  // tag parity compare
  logic tag_odd_parity;
  logic tag_mismatch;

  // requests dropped while disabled
  assign req_accept = read_valid && enabled;

  ////////////////////
  // request register
  ////////////////////

  // outstanding flag
  // high for exactly the cycle after an accepted request
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= req_accept;
    end
  end

  // request fields
  // only looked at while req_valid_q is high
  always_ff @(posedge clock) begin
    if (req_accept) begin
      req_tag_q        <= read_tag;
      req_tag_parity_q <= read_tag_parity;
      req_address_q    <= read_address;
    end
  end

  ////////////////////
  // data select
  ////////////////////

  // memories already hold data for req_tag_q
  // address zero means first half-line
  // idle port drives all ones
  always_comb begin
    if (!req_valid_q) begin
      read_data = '1;
    end else if (req_address_q == '0) begin
      read_data = ram_data_0;
    end else begin
      read_data = ram_data_1;
    end
  end

  ////////////////////
  // data parity
  ////////////////////

  // per-doubleword odd parity
  // follows read_data, idle value too
  assign read_parity = afu_buffer_pkg::dw_odd_parity(read_data);

  ////////////////////
  // tag parity
  ////////////////////

  // odd parity of the registered tag
  assign tag_odd_parity = ~(^req_tag_q);

  // compare against the host bit
  // only for an accepted request
  assign tag_mismatch = req_valid_q && (tag_odd_parity != req_tag_parity_q);

  // error pulse
  // one cycle, two cycles after the bad request
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_parity_error <= 1'b0;
    end else begin
      tag_parity_error <= tag_mismatch;
    end
  end

endmodule

// ==== rtl/half_line_ram.sv ====
`timescale 1ns/1ps

module half_line_ram #(
  parameter int WIDTH     = 512,
  parameter int ADDR_BITS = 8
) (
  input  logic                 clock,
  // write port
  input  logic                 we,
  input  logic [ADDR_BITS-1:0] wr_addr,
  input  logic [WIDTH-1:0]     data_in,
  // read port
  input  logic [ADDR_BITS-1:0] rd_addr,
  output logic [WIDTH-1:0]     data_out
);

  // one word per tag
  logic [WIDTH-1:0] mem [2**ADDR_BITS];

  ////////////////////
  // write
  ////////////////////

  always_ff @(posedge clock) begin
    if (we) begin
      mem[wr_addr] <= data_in;
    end
  end

  ////////////////////
  // read
  ////////////////////

  // registered read
  // data for rd_addr shows up next cycle
  always_ff @(posedge clock) begin
    data_out <= mem[rd_addr];
  end

endmodule

// ==== rtl/write_buffer_top.sv ====
`timescale 1ns/1ps

module write_buffer_top (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       enabled,
  // accelerator write side
  input  logic                       write_valid,
  input  afu_buffer_pkg::tag_t       write_tag,
  input  afu_buffer_pkg::half_line_t write_data_0,
  input  afu_buffer_pkg::half_line_t write_data_1,
  // host read side
  input  logic                       read_valid,
  input  afu_buffer_pkg::tag_t       read_tag,
  input  logic                       read_tag_parity,
  input  afu_buffer_pkg::read_addr_t read_address,
  output afu_buffer_pkg::half_line_t read_data,
  output afu_buffer_pkg::dw_parity_t read_parity,
  output logic                       tag_parity_error
);

  // memory geometry taken from the shared types
  localparam int LINE_BITS = $bits(afu_buffer_pkg::half_line_t);
  localparam int TAG_BITS  = $bits(afu_buffer_pkg::tag_t);

  // staged write
  logic                       wr_en;
  afu_buffer_pkg::tag_t       wr_tag;
  afu_buffer_pkg::half_line_t wr_data_0;
  afu_buffer_pkg::half_line_t wr_data_1;

  // memory read data
  afu_buffer_pkg::half_line_t ram_data_0;
  afu_buffer_pkg::half_line_t ram_data_1;

  ////////////////////
  // write side
  ////////////////////

  write_stage stage_i (
    .clock        (clock),
    .rstn         (rstn),
    .write_valid  (write_valid),
    .write_tag    (write_tag),
    .write_data_0 (write_data_0),
    .write_data_1 (write_data_1),
    .wr_en        (wr_en),
    .wr_tag       (wr_tag),
    .wr_data_0    (wr_data_0),
    .wr_data_1    (wr_data_1)
  );

  ////////////////////
  // storage
  ////////////////////

  // first half-line
  half_line_ram #(
    .WIDTH     (LINE_BITS),
    .ADDR_BITS (TAG_BITS)
  ) ram_0_i (
    .clock    (clock),
    .we       (wr_en),
    .wr_addr  (wr_tag),
    .data_in  (wr_data_0),
    .rd_addr  (read_tag),
    .data_out (ram_data_0)
  );

  // second half-line
  half_line_ram #(
    .WIDTH     (LINE_BITS),
    .ADDR_BITS (TAG_BITS)
  ) ram_1_i (
    .clock    (clock),
    .we       (wr_en),
    .wr_addr  (wr_tag),
    .data_in  (wr_data_1),
    .rd_addr  (read_tag),
    .data_out (ram_data_1)
  );

  ////////////////////
  // read side
  ////////////////////

  buffer_read_port port_i (
    .clock            (clock),
    .rstn             (rstn),
    .enabled          (enabled),
    .read_valid       (read_valid),
    .read_tag         (read_tag),
    .read_tag_parity  (read_tag_parity),
    .read_address     (read_address),
    .ram_data_0       (ram_data_0),
    .ram_data_1       (ram_data_1),
    .read_data        (read_data),
    .read_parity      (read_parity),
    .tag_parity_error (tag_parity_error)
  );

endmodule

// ==== rtl/write_stage.sv ====
`timescale 1ns/1ps

module write_stage (
  input  logic                       clock,
  input  logic                       rstn,
  // accelerator write side
  input  logic                       write_valid,
  input  afu_buffer_pkg::tag_t       write_tag,
  input  afu_buffer_pkg::half_line_t write_data_0,
  input  afu_buffer_pkg::half_line_t write_data_1,
  // aligned write to both memories
  output logic                       wr_en,
  output afu_buffer_pkg::tag_t       wr_tag,
  output afu_buffer_pkg::half_line_t wr_data_0,
  output afu_buffer_pkg::half_line_t wr_data_1
);

  ////////////////////
  // strobe
  ////////////////////

  // write enable for the memories
  // one cycle behind write_valid
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= write_valid;
    end
  end

  ////////////////////
  // payload
  ////////////////////

  // tag and both halves captured together
  // so the two memories see one consistent write
  // held when no strobe comes in
  always_ff @(posedge clock) begin
    if (write_valid) begin
      wr_tag    <= write_tag;
      wr_data_0 <= write_data_0;
      wr_data_1 <= write_data_1;
    end
  end

endmodule
